/* rtl/pipeCtrlPkg.sv */
/*
 * Pipeline control package
 * Opcode, ALU control, immediate type, result source and forwarding
 * encodings shared by the RV32I control path
 */
`default_nettype none

package pipeCtrlPkg;

    // Supported RV32I major opcodes
    typedef enum logic [6:0] {
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opRType  = 7'b0110011,
        opBranch = 7'b1100011,
        opIType  = 7'b0010011,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opLui    = 7'b0110111
    } opcodeT;

    // ALU operation as seen by the execute stage
    // Codes 4, 6 and 7 unused
    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluSlt = 3'd5
    } aluCtrlT;

    // Main decoder to ALU decoder hint
    typedef enum logic [1:0] {
        aluOpMem    = 2'd0,
        aluOpBranch = 2'd1,
        aluOpFunct  = 2'd2
    } aluOpT;

    // Immediate format for the datapath extender
    typedef enum logic [2:0] {
        immI = 3'd0,
        immS = 3'd1,
        immB = 3'd2,
        immJ = 3'd3,
        immU = 3'd4
    } immSrcT;

    // Writeback result mux select
    typedef enum logic [1:0] {
        resAlu     = 2'd0,
        resMem     = 2'd1,
        resPcPlus4 = 2'd2,
        resImm     = 2'd3
    } resultSrcT;

    // Execute-stage operand source
    typedef enum logic [1:0] {
        fwdNone = 2'd0,
        fwdWb   = 2'd1,
        fwdMem  = 2'd2
    } forwardT;

    // funct3 codes for ALU ops
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    // funct3 codes for branches
    localparam logic [2:0] f3Beq    = 3'b000;
    localparam logic [2:0] f3Bne    = 3'b001;

endpackage

`default_nettype wire

/* rtl/instrDecoder.sv */
/*
 * Instruction decoder
 * Main decoder and ALU decoder for the decode stage
 * Unknown opcodes and funct3 values give write-free control
 */
`default_nettype none

module instrDecoder (
    input  wire pipeCtrlPkg::opcodeT    opcode_i,
    input  wire logic [2:0]             funct3_i,
    input  wire logic                   funct7b5_i,
    output logic                        regWriteD_o,
    output logic                        memWriteD_o,
    output logic                        jumpD_o,
    output logic                        branchD_o,
    output logic                        branchTypeD_o,
    output logic                        aluSrcD_o,
    output pipeCtrlPkg::immSrcT         immSrcD_o,
    output pipeCtrlPkg::resultSrcT      resultSrcD_o,
    output pipeCtrlPkg::aluCtrlT        aluCtrlD_o
);

    pipeCtrlPkg::aluOpT aluOp;
    logic               aluFunct3Ok;
    logic               branchFunct3Ok;
    logic               rTypeSub;

    // funct3 values the ALU and branch unit can actually execute
    assign aluFunct3Ok = (funct3_i == pipeCtrlPkg::f3AddSub) ||
                         (funct3_i == pipeCtrlPkg::f3Slt) ||
                         (funct3_i == pipeCtrlPkg::f3Or) ||
                         (funct3_i == pipeCtrlPkg::f3And);
    assign branchFunct3Ok = (funct3_i == pipeCtrlPkg::f3Beq) ||
                            (funct3_i == pipeCtrlPkg::f3Bne);

    // Main decoder
    always_comb begin
        // Defaults are the no-op control set
        regWriteD_o  = 1'b0;
        memWriteD_o  = 1'b0;
        jumpD_o      = 1'b0;
        branchD_o    = 1'b0;
        aluSrcD_o    = 1'b0;
        immSrcD_o    = pipeCtrlPkg::immI;
        resultSrcD_o = pipeCtrlPkg::resAlu;
        aluOp        = pipeCtrlPkg::aluOpMem;
        case (opcode_i)
            pipeCtrlPkg::opLoad: begin
                regWriteD_o  = 1'b1;
                aluSrcD_o    = 1'b1;
                resultSrcD_o = pipeCtrlPkg::resMem;
            end
            pipeCtrlPkg::opStore: begin
                memWriteD_o = 1'b1;
                aluSrcD_o   = 1'b1;
                immSrcD_o   = pipeCtrlPkg::immS;
            end
            pipeCtrlPkg::opRType: begin
                regWriteD_o = aluFunct3Ok;
                aluOp       = pipeCtrlPkg::aluOpFunct;
            end
            pipeCtrlPkg::opBranch: begin
                // Only beq and bne may redirect the PC
                branchD_o = branchFunct3Ok;
                immSrcD_o = pipeCtrlPkg::immB;
                aluOp     = pipeCtrlPkg::aluOpBranch;
            end
            pipeCtrlPkg::opIType: begin
                regWriteD_o = aluFunct3Ok;
                aluSrcD_o   = 1'b1;
                aluOp       = pipeCtrlPkg::aluOpFunct;
            end
            pipeCtrlPkg::opJal: begin
                regWriteD_o  = 1'b1;
                jumpD_o      = 1'b1;
                immSrcD_o    = pipeCtrlPkg::immJ;
                resultSrcD_o = pipeCtrlPkg::resPcPlus4;
            end
            pipeCtrlPkg::opJalr: begin
                // Target is rs1 plus the I immediate
                regWriteD_o  = 1'b1;
                jumpD_o      = 1'b1;
                aluSrcD_o    = 1'b1;
                resultSrcD_o = pipeCtrlPkg::resPcPlus4;
            end
            pipeCtrlPkg::opLui: begin
                regWriteD_o  = 1'b1;
                immSrcD_o    = pipeCtrlPkg::immU;
                resultSrcD_o = pipeCtrlPkg::resImm;
            end
            default: begin
            end
        endcase
    end

    // Sub only for R-type, bit 5 separates it from I-type
    assign rTypeSub = funct7b5_i & opcode_i[5];

    // ALU decoder
    always_comb begin
        case (aluOp)
            pipeCtrlPkg::aluOpMem:    aluCtrlD_o = pipeCtrlPkg::aluAdd;
            pipeCtrlPkg::aluOpBranch: aluCtrlD_o = pipeCtrlPkg::aluSub;
            pipeCtrlPkg::aluOpFunct: begin
                case (funct3_i)
                    pipeCtrlPkg::f3AddSub:
                        aluCtrlD_o = rTypeSub ? pipeCtrlPkg::aluSub : pipeCtrlPkg::aluAdd;
                    pipeCtrlPkg::f3Slt: aluCtrlD_o = pipeCtrlPkg::aluSlt;
                    pipeCtrlPkg::f3Or:  aluCtrlD_o = pipeCtrlPkg::aluOr;
                    pipeCtrlPkg::f3And: aluCtrlD_o = pipeCtrlPkg::aluAnd;
                    default:            aluCtrlD_o = pipeCtrlPkg::aluAdd;
                endcase
            end
            default: aluCtrlD_o = pipeCtrlPkg::aluAdd;
        endcase
    end

    // Inverts Zero in execute, bne only
    assign branchTypeD_o = branchD_o && (funct3_i == pipeCtrlPkg::f3Bne);

endmodule

`default_nettype wire

/* rtl/stageControl.sv */
/*
 * Stage control
 * Carries decode control through execute, memory and writeback
 * and resolves branches and jumps in execute
 */
`default_nettype none

module stageControl (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   flushE_i,
    input  wire logic                   zeroE_i,
    input  wire logic                   regWriteD_i,
    input  wire logic                   memWriteD_i,
    input  wire logic                   jumpD_i,
    input  wire logic                   branchD_i,
    input  wire logic                   branchTypeD_i,
    input  wire logic                   aluSrcD_i,
    input  wire pipeCtrlPkg::resultSrcT resultSrcD_i,
    input  wire pipeCtrlPkg::aluCtrlT   aluCtrlD_i,
    output pipeCtrlPkg::aluCtrlT        aluCtrlE_o,
    output logic                        aluSrcE_o,
    output logic                        pcSrcE_o,
    output pipeCtrlPkg::resultSrcT      resultSrcE_o,
    output logic                        memWriteM_o,
    output pipeCtrlPkg::resultSrcT      resultSrcM_o,
    output logic                        regWriteM_o,
    output logic                        regWriteW_o,
    output pipeCtrlPkg::resultSrcT      resultSrcW_o
);

    // Execute-only control bits
    logic regWriteE;
    logic memWriteE;
    logic jumpE;
    logic branchE;
    logic branchTypeE;

    // Execute registers
    // A flush loads a bubble
    always_ff @(posedge clk) begin
        if (reset || flushE_i) begin
            regWriteE    <= 1'b0;
            memWriteE    <= 1'b0;
            jumpE        <= 1'b0;
            branchE      <= 1'b0;
            branchTypeE  <= 1'b0;
            aluSrcE_o    <= 1'b0;
            resultSrcE_o <= pipeCtrlPkg::resAlu;
            aluCtrlE_o   <= pipeCtrlPkg::aluAdd;
        end else begin
            regWriteE    <= regWriteD_i;
            memWriteE    <= memWriteD_i;
            jumpE        <= jumpD_i;
            branchE      <= branchD_i;
            branchTypeE  <= branchTypeD_i;
            aluSrcE_o    <= aluSrcD_i;
            resultSrcE_o <= resultSrcD_i;
            aluCtrlE_o   <= aluCtrlD_i;
        end
    end

    // Taken branch or any jump
    assign pcSrcE_o = (branchE & (zeroE_i ^ branchTypeE)) | jumpE;

    // Memory registers, no flush here
    always_ff @(posedge clk) begin
        if (reset) begin
            regWriteM_o  <= 1'b0;
            memWriteM_o  <= 1'b0;
            resultSrcM_o <= pipeCtrlPkg::resAlu;
        end else begin
            regWriteM_o  <= regWriteE;
            memWriteM_o  <= memWriteE;
            resultSrcM_o <= resultSrcE_o;
        end
    end

    // Writeback registers
    always_ff @(posedge clk) begin
        if (reset) begin
            regWriteW_o  <= 1'b0;
            resultSrcW_o <= pipeCtrlPkg::resAlu;
        end else begin
            regWriteW_o  <= regWriteM_o;
            resultSrcW_o <= resultSrcM_o;
        end
    end

    // Bubble reaches memory two edges after the flush request
    noWriteAfterFlush: assert property (
        @(posedge clk) (reset || flushE_i) |=> ##1 (!regWriteM_o && !memWriteM_o)
    ) else $error("write in memory stage after flush or reset");

endmodule

`default_nettype wire

/* rtl/hazardUnit.sv */
/*
 * Hazard unit
 * Forwarding selects for the execute operands,
 * load-use stall and flush requests
 */
`default_nettype none

module hazardUnit (
    input  wire logic [4:0]             rs1D_i,
    input  wire logic [4:0]             rs2D_i,
    input  wire logic [4:0]             rs1E_i,
    input  wire logic [4:0]             rs2E_i,
    input  wire logic [4:0]             rdE_i,
    input  wire logic [4:0]             rdM_i,
    input  wire logic [4:0]             rdW_i,
    input  wire pipeCtrlPkg::resultSrcT resultSrcE_i,
    input  wire logic                   regWriteM_i,
    input  wire logic                   regWriteW_i,
    input  wire logic                   mispredict_i,
    output pipeCtrlPkg::forwardT        forwardAE_o,
    output pipeCtrlPkg::forwardT        forwardBE_o,
    output logic                        stallF_o,
    output logic                        stallD_o,
    output logic                        flushD_o,
    output logic                        flushE_o
);

    logic lwStall;

    // Youngest producer wins, x0 never forwarded
    function automatic pipeCtrlPkg::forwardT fwdSel(input logic [4:0] rs,
                                                    input logic [4:0] rdMem,
                                                    input logic       writeMem,
                                                    input logic [4:0] rdWb,
                                                    input logic       writeWb);
        pipeCtrlPkg::forwardT sel;
        if ((rs != 5'd0) && writeMem && (rs == rdMem)) begin
            sel = pipeCtrlPkg::fwdMem;
        end else if ((rs != 5'd0) && writeWb && (rs == rdWb)) begin
            sel = pipeCtrlPkg::fwdWb;
        end else begin
            sel = pipeCtrlPkg::fwdNone;
        end
        return sel;
    endfunction

    assign forwardAE_o = fwdSel(rs1E_i, rdM_i, regWriteM_i, rdW_i, regWriteW_i);
    assign forwardBE_o = fwdSel(rs2E_i, rdM_i, regWriteM_i, rdW_i, regWriteW_i);

    // Load in execute feeding the instruction in decode
    assign lwStall = (resultSrcE_i == pipeCtrlPkg::resMem) && (rdE_i != 5'd0) &&
                     ((rs1D_i == rdE_i) || (rs2D_i == rdE_i));

    // Hold fetch and decode, bubble into execute
    assign stallF_o = lwStall;
    assign stallD_o = lwStall;

    // Wrong-path instructions in decode and execute are dropped
    assign flushD_o = mispredict_i;
    assign flushE_o = lwStall | mispredict_i;

endmodule

`default_nettype wire

/* rtl/pipelineController.sv */
/*
 * Pipeline controller top level
 * Decoder, stage control and hazard unit of the RV32I core
 */
`default_nettype none

module pipelineController (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire pipeCtrlPkg::opcodeT    opcode_i,
    input  wire logic [2:0]             funct3_i,
    input  wire logic                   funct7b5_i,
    input  wire logic                   zeroE_i,
    input  wire logic [4:0]             rs1D_i,
    input  wire logic [4:0]             rs2D_i,
    input  wire logic [4:0]             rs1E_i,
    input  wire logic [4:0]             rs2E_i,
    input  wire logic [4:0]             rdE_i,
    input  wire logic [4:0]             rdM_i,
    input  wire logic [4:0]             rdW_i,
    input  wire logic                   mispredict_i,
    output pipeCtrlPkg::immSrcT         immSrcD_o,
    output pipeCtrlPkg::aluCtrlT        aluCtrlE_o,
    output logic                        aluSrcE_o,
    output logic                        pcSrcE_o,
    output logic                        memWriteM_o,
    output pipeCtrlPkg::resultSrcT      resultSrcM_o,
    output logic                        regWriteW_o,
    output pipeCtrlPkg::resultSrcT      resultSrcW_o,
    output pipeCtrlPkg::forwardT        forwardAE_o,
    output pipeCtrlPkg::forwardT        forwardBE_o,
    output logic                        stallF_o,
    output logic                        stallD_o,
    output logic                        flushD_o,
    output logic                        flushE_o
);

    // Decode-stage control
    logic                   regWriteD;
    logic                   memWriteD;
    logic                   jumpD;
    logic                   branchD;
    logic                   branchTypeD;
    logic                   aluSrcD;
    pipeCtrlPkg::resultSrcT resultSrcD;
    pipeCtrlPkg::aluCtrlT   aluCtrlD;

    // Stage state seen by the hazard unit
    pipeCtrlPkg::resultSrcT resultSrcE;
    logic                   regWriteM;

    instrDecoder decoder (
        .opcode_i      (opcode_i),
        .funct3_i      (funct3_i),
        .funct7b5_i    (funct7b5_i),
        .regWriteD_o   (regWriteD),
        .memWriteD_o   (memWriteD),
        .jumpD_o       (jumpD),
        .branchD_o     (branchD),
        .branchTypeD_o (branchTypeD),
        .aluSrcD_o     (aluSrcD),
        .immSrcD_o     (immSrcD_o),
        .resultSrcD_o  (resultSrcD),
        .aluCtrlD_o    (aluCtrlD)
    );

    // Flush from the hazard unit clears the execute registers
    stageControl execute (
        .clk           (clk),
        .reset         (reset),
        .flushE_i      (flushE_o),
        .zeroE_i       (zeroE_i),
        .regWriteD_i   (regWriteD),
        .memWriteD_i   (memWriteD),
        .jumpD_i       (jumpD),
        .branchD_i     (branchD),
        .branchTypeD_i (branchTypeD),
        .aluSrcD_i     (aluSrcD),
        .resultSrcD_i  (resultSrcD),
        .aluCtrlD_i    (aluCtrlD),
        .aluCtrlE_o    (aluCtrlE_o),
        .aluSrcE_o     (aluSrcE_o),
        .pcSrcE_o      (pcSrcE_o),
        .resultSrcE_o  (resultSrcE),
        .memWriteM_o   (memWriteM_o),
        .resultSrcM_o  (resultSrcM_o),
        .regWriteM_o   (regWriteM),
        .regWriteW_o   (regWriteW_o),
        .resultSrcW_o  (resultSrcW_o)
    );

    hazardUnit result (
        .rs1D_i        (rs1D_i),
        .rs2D_i        (rs2D_i),
        .rs1E_i        (rs1E_i),
        .rs2E_i        (rs2E_i),
        .rdE_i         (rdE_i),
        .rdM_i         (rdM_i),
        .rdW_i         (rdW_i),
        .resultSrcE_i  (resultSrcE),
        .regWriteM_i   (regWriteM),
        .regWriteW_i   (regWriteW_o),
        .mispredict_i  (mispredict_i),
        .forwardAE_o   (forwardAE_o),
        .forwardBE_o   (forwardBE_o),
        .stallF_o      (stallF_o),
        .stallD_o      (stallD_o),
        .flushD_o      (flushD_o),
        .flushE_o      (flushE_o)
    );

endmodule

`default_nettype wire

/* tb/controllerTb.sv */
/*
 * Testbench for the pipeline controller
 * Directed tests of decode, ALU control, branch resolution,
 * forwarding, load-use stall and mispredict flush
 */
`default_nettype none

module controllerTb;

    timeunit 1ns;
    timeprecision 1ps;

    // Sum of test lengths is about 200 cycles
    localparam int cycleLimit = 400;
    // Not a supported opcode, decodes to a bubble
    localparam logic [6:0] nopCode = 7'b0000000;

    logic                   clk;
    logic                   reset;
    pipeCtrlPkg::opcodeT    opcode;
    logic [2:0]             funct3;
    logic                   funct7b5;
    logic                   zeroE;
    logic [4:0]             rs1D;
    logic [4:0]             rs2D;
    logic [4:0]             rs1E;
    logic [4:0]             rs2E;
    logic [4:0]             rdE;
    logic [4:0]             rdM;
    logic [4:0]             rdW;
    logic                   mispredict;
    pipeCtrlPkg::immSrcT    immSrcD;
    pipeCtrlPkg::aluCtrlT   aluCtrlE;
    logic                   aluSrcE;
    logic                   pcSrcE;
    logic                   memWriteM;
    pipeCtrlPkg::resultSrcT resultSrcM;
    logic                   regWriteW;
    pipeCtrlPkg::resultSrcT resultSrcW;
    pipeCtrlPkg::forwardT   forwardAE;
    pipeCtrlPkg::forwardT   forwardBE;
    logic                   stallF;
    logic                   stallD;
    logic                   flushD;
    logic                   flushE;

    int          errorCount;
    int          checkCount;
    int          cycleCount;
    logic [31:0] lcgState;

    pipelineController uut (
        .clk(clk), .reset(reset), .opcode_i(opcode), .funct3_i(funct3),
        .funct7b5_i(funct7b5), .zeroE_i(zeroE), .rs1D_i(rs1D), .rs2D_i(rs2D),
        .rs1E_i(rs1E), .rs2E_i(rs2E), .rdE_i(rdE), .rdM_i(rdM), .rdW_i(rdW),
        .mispredict_i(mispredict), .immSrcD_o(immSrcD), .aluCtrlE_o(aluCtrlE),
        .aluSrcE_o(aluSrcE), .pcSrcE_o(pcSrcE), .memWriteM_o(memWriteM),
        .resultSrcM_o(resultSrcM), .regWriteW_o(regWriteW), .resultSrcW_o(resultSrcW),
        .forwardAE_o(forwardAE), .forwardBE_o(forwardBE), .stallF_o(stallF),
        .stallD_o(stallD), .flushD_o(flushD), .flushE_o(flushE)
    );

    // 4 ns clock
    always #2 clk = ~clk;

    // Watchdog
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: tests did not finish within %0d cycles", cycleLimit);
            $display("Test failed");
            $finish;
        end
    end

    // LCG with the classic C library constants
    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    // Nonzero register from the upper LCG bits
    function automatic logic [4:0] randomReg();
        logic [31:0] value;
        logic [4:0]  r;
        r = 5'd0;
        while (r == 5'd0) begin
            value = nextRandom();
            r = value[31:27];
        end
        return r;
    endfunction

    // Memory stage before writeback, x0 never forwarded
    function automatic logic [1:0] expectedForward(input logic [4:0] src,
                                                   input logic [4:0] destM, input logic writeM,
                                                   input logic [4:0] destW, input logic writeW);
        if (src == 5'd0) return pipeCtrlPkg::fwdNone;
        if (writeM && src == destM) return pipeCtrlPkg::fwdMem;
        if (writeW && src == destW) return pipeCtrlPkg::fwdWb;
        return pipeCtrlPkg::fwdNone;
    endfunction

    task automatic checkEq(input string testName, input string sigName,
                           input logic [31:0] expected, input logic [31:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("ERROR %s: %s expected %0d, actual %0d", testName, sigName,
                     expected, actual);
        end
    endtask

    task automatic driveInstr(input logic [6:0] op, input logic [2:0] f3, input logic f7);
        opcode   = pipeCtrlPkg::opcodeT'(op);
        funct3   = f3;
        funct7b5 = f7;
    endtask

    // Datapath-side inputs back to a hazard-free state
    task automatic clearSideInputs();
        zeroE      = 1'b0;
        rs1D       = 5'd0;
        rs2D       = 5'd0;
        rs1E       = 5'd0;
        rs2E       = 5'd0;
        rdE        = 5'd0;
        rdM        = 5'd0;
        rdW        = 5'd0;
        mispredict = 1'b0;
    endtask

    task automatic checkAfterReset();
        @(negedge clk);
        // Matching registers, only the cleared write enables keep fwdNone
        rs1E = 5'd3;
        rdM  = 5'd3;
        rs2E = 5'd4;
        rdW  = 5'd4;
        #1;
        checkEq("reset", "regWriteW", 0, regWriteW);
        checkEq("reset", "memWriteM", 0, memWriteM);
        checkEq("reset", "pcSrcE", 0, pcSrcE);
        checkEq("reset", "forwardAE", pipeCtrlPkg::fwdNone, forwardAE);
        checkEq("reset", "forwardBE", pipeCtrlPkg::fwdNone, forwardBE);
        clearSideInputs();
    endtask

    // One instruction followed by bubbles, checked in each stage
    task automatic decodeCase(input string name, input logic [6:0] op, input logic [2:0] expImm,
                              input logic expAluSrc, input logic expMemWrite,
                              input logic [1:0] expResult, input logic expRegWrite);
        @(negedge clk);
        driveInstr(op, 3'b000, 1'b0);
        #1;
        checkEq(name, "immSrcD", expImm, immSrcD);
        @(negedge clk);
        driveInstr(nopCode, 3'b000, 1'b0);
        #1;
        checkEq(name, "aluSrcE", expAluSrc, aluSrcE);
        @(negedge clk);
        #1;
        checkEq(name, "memWriteM", expMemWrite, memWriteM);
        checkEq(name, "resultSrcM", expResult, resultSrcM);
        @(negedge clk);
        #1;
        checkEq(name, "regWriteW", expRegWrite, regWriteW);
        checkEq(name, "resultSrcW", expResult, resultSrcW);
    endtask

    task automatic testDecodeTable();
        decodeCase("decode lw", pipeCtrlPkg::opLoad, pipeCtrlPkg::immI, 1, 0,
                   pipeCtrlPkg::resMem, 1);
        decodeCase("decode sw", pipeCtrlPkg::opStore, pipeCtrlPkg::immS, 1, 1,
                   pipeCtrlPkg::resAlu, 0);
        decodeCase("decode rtype", pipeCtrlPkg::opRType, pipeCtrlPkg::immI, 0, 0,
                   pipeCtrlPkg::resAlu, 1);
        decodeCase("decode beq", pipeCtrlPkg::opBranch, pipeCtrlPkg::immB, 0, 0,
                   pipeCtrlPkg::resAlu, 0);
        decodeCase("decode itype", pipeCtrlPkg::opIType, pipeCtrlPkg::immI, 1, 0,
                   pipeCtrlPkg::resAlu, 1);
        decodeCase("decode jal", pipeCtrlPkg::opJal, pipeCtrlPkg::immJ, 0, 0,
                   pipeCtrlPkg::resPcPlus4, 1);
        decodeCase("decode jalr", pipeCtrlPkg::opJalr, pipeCtrlPkg::immI, 1, 0,
                   pipeCtrlPkg::resPcPlus4, 1);
        decodeCase("decode lui", pipeCtrlPkg::opLui, pipeCtrlPkg::immU, 0, 0,
                   pipeCtrlPkg::resImm, 1);
        // Unknown opcode must not write anything
        decodeCase("decode unknown", 7'b1111111, pipeCtrlPkg::immI, 0, 0,
                   pipeCtrlPkg::resAlu, 0);
    endtask

    task automatic aluCase(input string name, input logic [6:0] op, input logic [2:0] f3,
                           input logic f7, input logic [2:0] expAlu);
        @(negedge clk);
        driveInstr(op, f3, f7);
        @(negedge clk);
        driveInstr(nopCode, 3'b000, 1'b0);
        #1;
        checkEq(name, "aluCtrlE", expAlu, aluCtrlE);
    endtask

    task automatic testAluControl();
        aluCase("alu r add", pipeCtrlPkg::opRType, 3'b000, 0, pipeCtrlPkg::aluAdd);
        aluCase("alu r sub", pipeCtrlPkg::opRType, 3'b000, 1, pipeCtrlPkg::aluSub);
        aluCase("alu r slt", pipeCtrlPkg::opRType, 3'b010, 1, pipeCtrlPkg::aluSlt);
        aluCase("alu r or", pipeCtrlPkg::opRType, 3'b110, 0, pipeCtrlPkg::aluOr);
        aluCase("alu r and", pipeCtrlPkg::opRType, 3'b111, 0, pipeCtrlPkg::aluAnd);
        // Immediate bit 5 set must not turn addi into sub
        aluCase("alu i add", pipeCtrlPkg::opIType, 3'b000, 1, pipeCtrlPkg::aluAdd);
        aluCase("alu i slt", pipeCtrlPkg::opIType, 3'b010, 0, pipeCtrlPkg::aluSlt);
        aluCase("alu i or", pipeCtrlPkg::opIType, 3'b110, 0, pipeCtrlPkg::aluOr);
        aluCase("alu i and", pipeCtrlPkg::opIType, 3'b111, 0, pipeCtrlPkg::aluAnd);
        aluCase("alu r unsupported", pipeCtrlPkg::opRType, 3'b001, 0, pipeCtrlPkg::aluAdd);
        aluCase("alu lw", pipeCtrlPkg::opLoad, 3'b010, 0, pipeCtrlPkg::aluAdd);
        aluCase("alu sw", pipeCtrlPkg::opStore, 3'b010, 1, pipeCtrlPkg::aluAdd);
        aluCase("alu beq", pipeCtrlPkg::opBranch, 3'b000, 0, pipeCtrlPkg::aluSub);
        aluCase("alu bne", pipeCtrlPkg::opBranch, 3'b001, 0, pipeCtrlPkg::aluSub);
    endtask

    // Zero flag arrives while the instruction sits in execute
    task automatic branchCase(input string name, input logic [6:0] op, input logic [2:0] f3,
                              input logic zero, input logic expPcSrc);
        @(negedge clk);
        zeroE = 1'b0;
        driveInstr(op, f3, 1'b0);
        @(negedge clk);
        driveInstr(nopCode, 3'b000, 1'b0);
        zeroE = zero;
        #1;
        checkEq(name, "pcSrcE", expPcSrc, pcSrcE);
    endtask

    task automatic testBranches();
        branchCase("beq taken", pipeCtrlPkg::opBranch, 3'b000, 1, 1);
        branchCase("beq not taken", pipeCtrlPkg::opBranch, 3'b000, 0, 0);
        branchCase("bne not taken", pipeCtrlPkg::opBranch, 3'b001, 1, 0);
        branchCase("bne taken", pipeCtrlPkg::opBranch, 3'b001, 0, 1);
        branchCase("jal zero low", pipeCtrlPkg::opJal, 3'b000, 0, 1);
        branchCase("jal zero high", pipeCtrlPkg::opJal, 3'b000, 1, 1);
        branchCase("jalr", pipeCtrlPkg::opJalr, 3'b000, 0, 1);
        branchCase("rtype no branch", pipeCtrlPkg::opRType, 3'b000, 1, 0);
        branchCase("lw no branch", pipeCtrlPkg::opLoad, 3'b010, 1, 0);
    endtask

    // Older instruction ends in writeback, younger in memory
    task automatic forwardCase(input string name, input logic olderWrites,
                               input logic youngerWrites, input logic [4:0] srcA,
                               input logic [4:0] srcB, input logic [4:0] destM,
                               input logic [4:0] destW);
        logic [1:0] expA;
        logic [1:0] expB;
        expA = expectedForward(srcA, destM, youngerWrites, destW, olderWrites);
        expB = expectedForward(srcB, destM, youngerWrites, destW, olderWrites);
        @(negedge clk);
        driveInstr(olderWrites ? pipeCtrlPkg::opRType : pipeCtrlPkg::opStore, 3'b000, 0);
        @(negedge clk);
        driveInstr(youngerWrites ? pipeCtrlPkg::opRType : pipeCtrlPkg::opStore, 3'b000, 0);
        @(negedge clk);
        driveInstr(nopCode, 3'b000, 1'b0);
        @(negedge clk);
        rs1E = srcA;
        rs2E = srcB;
        rdM  = destM;
        rdW  = destW;
        #1;
        checkEq(name, "forwardAE", expA, forwardAE);
        checkEq(name, "forwardBE", expB, forwardBE);
    endtask

    task automatic testForwarding();
        logic [4:0] regA;
        logic [4:0] regB;
        repeat (4) begin
            regA = randomReg();
            regB = randomReg();
            while (regB == regA) begin
                regB = randomReg();
            end
            forwardCase("fwd split", 1, 1, regA, regB, regA, regB);
            forwardCase("fwd mem wins", 1, 1, regA, regA, regA, regA);
            forwardCase("fwd mem no write", 1, 0, regA, regB, regA, regA);
            forwardCase("fwd wb no write", 0, 1, regB, regA, regA, regB);
            forwardCase("fwd x0", 1, 1, 5'd0, 5'd0, 5'd0, 5'd0);
        end
    endtask

    task automatic testLoadUse();
        logic [4:0] loadDest;
        loadDest = randomReg();
        @(negedge clk);
        clearSideInputs();
        driveInstr(pipeCtrlPkg::opLoad, 3'b010, 1'b0);
        // Store in decode reads the loaded register
        @(negedge clk);
        driveInstr(pipeCtrlPkg::opStore, 3'b010, 1'b0);
        rdE  = loadDest;
        rs2D = loadDest;
        #1;
        checkEq("load-use", "stallF", 1, stallF);
        checkEq("load-use", "stallD", 1, stallD);
        checkEq("load-use", "flushE", 1, flushE);
        checkEq("load-use", "flushD", 0, flushD);
        @(negedge clk);
        driveInstr(nopCode, 3'b000, 1'b0);
        rdE  = 5'd0;
        rs2D = 5'd0;
        #1;
        checkEq("load-use bubble", "aluCtrlE", pipeCtrlPkg::aluAdd, aluCtrlE);
        checkEq("load-use bubble", "aluSrcE", 0, aluSrcE);
        @(negedge clk);
        #1;
        checkEq("load-use bubble", "memWriteM", 0, memWriteM);
        @(negedge clk);
        #1;
        checkEq("load-use bubble", "regWriteW", 0, regWriteW);
        // Load to x0 never stalls
        @(negedge clk);
        driveInstr(pipeCtrlPkg::opLoad, 3'b010, 1'b0);
        @(negedge clk);
        driveInstr(pipeCtrlPkg::opRType, 3'b000, 1'b0);
        #1;
        checkEq("load x0", "stallF", 0, stallF);
        checkEq("load x0", "flushE", 0, flushE);
    endtask

    task automatic mispredictCase(input string name, input logic [6:0] op);
        @(negedge clk);
        clearSideInputs();
        driveInstr(op, 3'b000, 1'b0);
        mispredict = 1'b1;
        #1;
        checkEq(name, "flushD", 1, flushD);
        checkEq(name, "flushE", 1, flushE);
        checkEq(name, "stallF", 0, stallF);
        checkEq(name, "stallD", 0, stallD);
        @(negedge clk);
        driveInstr(nopCode, 3'b000, 1'b0);
        mispredict = 1'b0;
        #1;
        checkEq(name, "aluSrcE", 0, aluSrcE);
        checkEq(name, "pcSrcE", 0, pcSrcE);
        @(negedge clk);
        #1;
        checkEq(name, "memWriteM", 0, memWriteM);
        @(negedge clk);
        #1;
        checkEq(name, "regWriteW", 0, regWriteW);
    endtask

    initial begin
        errorCount = 0;
        checkCount = 0;
        cycleCount = 0;
        lcgState   = 32'h7b2e;
        clk        = 1'b0;
        reset      = 1'b1;
        clearSideInputs();
        driveInstr(nopCode, 3'b000, 1'b0);
        repeat (10) @(negedge clk);
        reset = 1'b0;
        checkAfterReset();
        testDecodeTable();
        testAluControl();
        testBranches();
        testForwarding();
        testLoadUse();
        mispredictCase("mispredict sw", pipeCtrlPkg::opStore);
        mispredictCase("mispredict rtype", pipeCtrlPkg::opRType);
        mispredictCase("mispredict jal", pipeCtrlPkg::opJal);
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
rtl/pipeCtrlPkg.sv
rtl/instrDecoder.sv
rtl/stageControl.sv
rtl/hazardUnit.sv
rtl/pipelineController.sv
tb/controllerTb.sv

/* Bender.yml */
package:
  name: pipeline_controller

sources:
  - files:
      - rtl/pipeCtrlPkg.sv
      - rtl/instrDecoder.sv
      - rtl/stageControl.sv
      - rtl/hazardUnit.sv
      - rtl/pipelineController.sv
  - target: test
    files:
      - tb/controllerTb.sv
